//--- design/ex_pkg.sv
`default_nettype none

package ex_pkg;

        localparam int DATA_W     = 32;
        localparam int REG_ADDR_W = 5;
        localparam int SHAMT_W    = 5;
        localparam int IMM_W      = 16;

        localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // Return address register

        // Main opcode field, bits 31:26 of the instruction
        typedef enum logic [5:0] {
                OP_RTYPE = 6'h00,
                OP_JAL   = 6'h03,
                OP_BEQ   = 6'h04,
                OP_BNE   = 6'h05,
                OP_ADDI  = 6'h08,
                OP_SLTI  = 6'h0a,
                OP_ANDI  = 6'h0c,
                OP_ORI   = 6'h0d,
                OP_XORI  = 6'h0e,
                OP_LUI   = 6'h0f,
                OP_LB    = 6'h20,
                OP_LH    = 6'h21,
                OP_LHU   = 6'h22,
                OP_LW    = 6'h23,
                OP_LWU   = 6'h24,
                OP_LBU   = 6'h25,
                OP_SB    = 6'h28,
                OP_SH    = 6'h29,
                OP_SW    = 6'h2b
        } opcode_e;

        // R-type function field, bits 5:0
        typedef enum logic [5:0] {
                FN_SLL  = 6'h00,
                FN_SRL  = 6'h02,
                FN_SRA  = 6'h03,
                FN_SLLV = 6'h04,
                FN_SRLV = 6'h06,
                FN_SRAV = 6'h07,
                FN_JALR = 6'h09,
                FN_ADD  = 6'h20,
                FN_ADDU = 6'h21,
                FN_SUB  = 6'h22,
                FN_SUBU = 6'h23,
                FN_AND  = 6'h24,
                FN_OR   = 6'h25,
                FN_XOR  = 6'h26,
                FN_NOR  = 6'h27,
                FN_SLT  = 6'h2a
        } funct_e;

        typedef enum logic [3:0] {
                ALU_SLL = 4'h0,
                ALU_SRL = 4'h1,
                ALU_SRA = 4'h2,
                ALU_ADD = 4'h3,
                ALU_SUB = 4'h4,
                ALU_AND = 4'h5,
                ALU_OR  = 4'h6,
                ALU_XOR = 4'h7,
                ALU_NOR = 4'h8,
                ALU_SLT = 4'h9,
                ALU_LUI = 4'ha,
                ALU_BEQ = 4'hb,
                ALU_BNE = 4'hc
        } alu_op_e;

        typedef enum logic [1:0] {
                DEST_NONE = 2'd0,
                DEST_RD   = 2'd1,
                DEST_RT   = 2'd2
        } dest_sel_e;

endpackage

`default_nettype wire

//--- design/ex_id_latch.sv
`timescale 1ns/1ps
`default_nettype none

module ex_id_latch (
        input  wire                                i_clk,
        input  wire                                i_rst_n,
        input  wire                                i_valid,
        input  ex_pkg::opcode_e                    i_opcode,
        input  ex_pkg::funct_e                     i_funct,
        input  wire [ex_pkg::SHAMT_W-1:0]          i_shamt,
        input  wire [ex_pkg::DATA_W-1:0]           i_rs_data,
        input  wire [ex_pkg::DATA_W-1:0]           i_rt_data,
        input  wire [ex_pkg::IMM_W-1:0]            i_imm,
        input  wire [ex_pkg::REG_ADDR_W-1:0]       i_rt_addr,
        input  wire [ex_pkg::REG_ADDR_W-1:0]       i_rd_addr,
        input  wire [ex_pkg::DATA_W-1:0]           i_pc_link,
        output logic                               o_valid,
        output ex_pkg::opcode_e                    o_opcode,
        output ex_pkg::funct_e                     o_funct,
        output logic [ex_pkg::SHAMT_W-1:0]         o_shamt,
        output logic [ex_pkg::DATA_W-1:0]          o_rs_data,
        output logic [ex_pkg::DATA_W-1:0]          o_rt_data,
        output logic [ex_pkg::DATA_W-1:0]          o_imm_ext,
        output logic                               o_imm_sel,
        output ex_pkg::dest_sel_e                  o_dest_sel,
        output logic                               o_mem_rd,
        output logic                               o_mem_wr,
        output logic [ex_pkg::REG_ADDR_W-1:0]      o_rt_addr,
        output logic [ex_pkg::REG_ADDR_W-1:0]      o_rd_addr,
        output logic [ex_pkg::DATA_W-1:0]          o_pc_link
);
        import ex_pkg::*;

        logic              zero_ext;
        logic              is_load;
        logic              is_store;
        logic              imm_sel;
        dest_sel_e         dest_sel;
        logic [DATA_W-1:0] imm_ext;

        always_comb begin
                zero_ext = (i_opcode inside {OP_ANDI, OP_ORI, OP_XORI}); // Logical immediates
                is_load  = (i_opcode inside {OP_LB, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LBU});
                is_store = (i_opcode inside {OP_SB, OP_SH, OP_SW});
                imm_sel  = !(i_opcode inside {OP_RTYPE, OP_JAL, OP_BEQ, OP_BNE});
                imm_ext  = zero_ext ? {{(DATA_W-IMM_W){1'b0}}, i_imm}
                                    : {{(DATA_W-IMM_W){i_imm[IMM_W-1]}}, i_imm};
                if (i_opcode == OP_RTYPE) begin
                        dest_sel = DEST_RD;
                end else if (i_opcode inside {OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI,
                                              OP_XORI, OP_LUI}) begin
                        dest_sel = DEST_RT;
                end else begin
                        dest_sel = DEST_NONE; // Branches, JAL, memory ops
                end
        end

        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        o_valid  <= 1'b0;
                        o_mem_rd <= 1'b0;
                        o_mem_wr <= 1'b0;
                end else begin
                        o_valid  <= i_valid;
                        o_mem_rd <= i_valid & is_load;  // No strobe on a bubble
                        o_mem_wr <= i_valid & is_store;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_valid) begin
                        o_opcode   <= i_opcode;
                        o_funct    <= i_funct;
                        o_shamt    <= i_shamt;
                        o_rs_data  <= i_rs_data;
                        o_rt_data  <= i_rt_data;
                        o_imm_ext  <= imm_ext;
                        o_imm_sel  <= imm_sel;
                        o_dest_sel <= dest_sel;
                        o_rt_addr  <= i_rt_addr;
                        o_rd_addr  <= i_rd_addr;
                        o_pc_link  <= i_pc_link;
                end
        end

endmodule

`default_nettype wire

//--- design/alu_control.sv
`timescale 1ns/1ps
`default_nettype none

module alu_control (
        input  ex_pkg::funct_e   i_funct_code,
        input  ex_pkg::opcode_e  i_alu_op,
        output ex_pkg::alu_op_e  o_alu_ctrl,
        output logic             o_shamt_ctrl, // 0 takes the shamt field, 1 takes rs
        output logic             o_r31_ctrl,
        output logic             o_illegal
);
        import ex_pkg::*;

        always_comb begin
                o_alu_ctrl   = ALU_ADD;
                o_shamt_ctrl = 1'b0;
                o_r31_ctrl   = 1'b0;
                o_illegal    = 1'b0;

                case (i_alu_op)
                        OP_RTYPE: begin
                                case (i_funct_code)
                                        FN_SLL:  o_alu_ctrl = ALU_SLL;
                                        FN_SRL:  o_alu_ctrl = ALU_SRL;
                                        FN_SRA:  o_alu_ctrl = ALU_SRA;
                                        FN_SLLV: begin
                                                o_alu_ctrl   = ALU_SLL;
                                                o_shamt_ctrl = 1'b1; // Amount from rs
                                        end
                                        FN_SRLV: begin
                                                o_alu_ctrl   = ALU_SRL;
                                                o_shamt_ctrl = 1'b1;
                                        end
                                        FN_SRAV: begin
                                                o_alu_ctrl   = ALU_SRA;
                                                o_shamt_ctrl = 1'b1;
                                        end
                                        FN_JALR: o_r31_ctrl = 1'b1; // Link value goes to r31
                                        FN_ADD,
                                        FN_ADDU: o_alu_ctrl = ALU_ADD; // No overflow trap
                                        FN_SUB,
                                        FN_SUBU: o_alu_ctrl = ALU_SUB;
                                        FN_AND:  o_alu_ctrl = ALU_AND;
                                        FN_OR:   o_alu_ctrl = ALU_OR;
                                        FN_XOR:  o_alu_ctrl = ALU_XOR;
                                        FN_NOR:  o_alu_ctrl = ALU_NOR;
                                        FN_SLT:  o_alu_ctrl = ALU_SLT;
                                        default: o_illegal  = 1'b1;
                                endcase
                        end
                        // Effective address is rs plus offset
                        OP_LB, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LBU,
                        OP_SB, OP_SH, OP_SW: o_alu_ctrl = ALU_ADD;
                        OP_ADDI: o_alu_ctrl = ALU_ADD;
                        OP_SLTI: o_alu_ctrl = ALU_SLT;
                        OP_ANDI: o_alu_ctrl = ALU_AND;
                        OP_ORI:  o_alu_ctrl = ALU_OR;
                        OP_XORI: o_alu_ctrl = ALU_XOR;
                        OP_LUI:  o_alu_ctrl = ALU_LUI;
                        OP_BEQ:  o_alu_ctrl = ALU_BEQ;
                        OP_BNE:  o_alu_ctrl = ALU_BNE;
                        OP_JAL:  o_r31_ctrl = 1'b1;
                        default: o_illegal  = 1'b1; // Unknown opcode
                endcase
        end

endmodule

`default_nettype wire

//--- design/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
        input  ex_pkg::alu_op_e                 i_alu_ctrl,
        input  wire                             i_shamt_ctrl,
        input  wire                             i_imm_sel,
        input  wire [ex_pkg::SHAMT_W-1:0]       i_shamt,
        input  wire [ex_pkg::DATA_W-1:0]        i_rs_data,
        input  wire [ex_pkg::DATA_W-1:0]        i_rt_data,
        input  wire [ex_pkg::DATA_W-1:0]        i_imm_ext,
        output logic [ex_pkg::DATA_W-1:0]       o_result,
        output logic                            o_branch_cond
);
        import ex_pkg::*;

        logic [DATA_W-1:0]  op_a;
        logic [DATA_W-1:0]  op_b;
        logic [SHAMT_W-1:0] shift_amt;

        assign op_a      = i_rs_data;
        assign op_b      = i_imm_sel ? i_imm_ext : i_rt_data;
        assign shift_amt = i_shamt_ctrl ? i_rs_data[SHAMT_W-1:0] : i_shamt; // Only low bits of rs

        always_comb begin
                o_branch_cond = 1'b0;
                case (i_alu_ctrl)
                        ALU_SLL: o_result = op_b << shift_amt;
                        ALU_SRL: o_result = op_b >> shift_amt;
                        ALU_SRA: o_result = $unsigned($signed(op_b) >>> shift_amt);
                        ALU_ADD: o_result = op_a + op_b;
                        ALU_SUB: o_result = op_a - op_b;
                        ALU_AND: o_result = op_a & op_b;
                        ALU_OR:  o_result = op_a | op_b;
                        ALU_XOR: o_result = op_a ^ op_b;
                        ALU_NOR: o_result = ~(op_a | op_b);
                        ALU_SLT: o_result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                        ALU_LUI: o_result = {op_b[IMM_W-1:0], {(DATA_W-IMM_W){1'b0}}};
                        ALU_BEQ: begin
                                o_result      = '0;
                                o_branch_cond = (i_rs_data == i_rt_data);
                        end
                        ALU_BNE: begin
                                o_result      = '0;
                                o_branch_cond = (i_rs_data != i_rt_data);
                        end
                        default: o_result = '0;
                endcase
        end

endmodule

`default_nettype wire

//--- design/ex_result_latch.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result_latch (
        input  wire                             i_clk,
        input  wire                             i_rst_n,
        input  wire                             i_valid,
        input  wire [ex_pkg::DATA_W-1:0]        i_alu_result,
        input  wire                             i_branch_cond,
        input  wire                             i_r31_ctrl,
        input  wire                             i_illegal,
        input  ex_pkg::dest_sel_e               i_dest_sel,
        input  wire                             i_mem_rd,
        input  wire                             i_mem_wr,
        input  wire [ex_pkg::REG_ADDR_W-1:0]    i_rt_addr,
        input  wire [ex_pkg::REG_ADDR_W-1:0]    i_rd_addr,
        input  wire [ex_pkg::DATA_W-1:0]        i_pc_link,
        input  ex_pkg::alu_op_e                 i_alu_op,
        output logic                            o_valid,
        output logic [ex_pkg::DATA_W-1:0]       o_result,
        output logic [ex_pkg::REG_ADDR_W-1:0]   o_wr_addr,
        output logic                            o_wr_en,
        output logic                            o_mem_rd,
        output logic                            o_mem_wr,
        output logic                            o_branch_taken
);
        import ex_pkg::*;

        logic                  live;
        logic                  is_branch;
        logic [REG_ADDR_W-1:0] wr_addr;

        assign live      = i_valid & ~i_illegal; // Illegal ops retire with no side effects
        assign is_branch = (i_alu_op == ALU_BEQ) || (i_alu_op == ALU_BNE);

        always_comb begin
                if (i_r31_ctrl)
                        wr_addr = LINK_REG;
                else if (i_dest_sel == DEST_RT)
                        wr_addr = i_rt_addr;
                else
                        wr_addr = i_rd_addr;
        end

        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        o_valid        <= 1'b0;
                        o_wr_en        <= 1'b0;
                        o_mem_rd       <= 1'b0;
                        o_mem_wr       <= 1'b0;
                        o_branch_taken <= 1'b0;
                end else begin
                        o_valid        <= i_valid;
                        o_wr_en        <= live & (i_r31_ctrl | (i_dest_sel != DEST_NONE));
                        o_mem_rd       <= live & i_mem_rd;
                        o_mem_wr       <= live & i_mem_wr;
                        o_branch_taken <= live & is_branch & i_branch_cond;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_valid) begin
                        o_result  <= i_r31_ctrl ? i_pc_link : i_alu_result;
                        o_wr_addr <= wr_addr;
                end
        end

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
        input  wire                             i_clk,
        input  wire                             i_rst_n,
        input  wire                             i_valid,
        input  ex_pkg::opcode_e                 i_opcode,
        input  ex_pkg::funct_e                  i_funct,
        input  wire [ex_pkg::SHAMT_W-1:0]       i_shamt,
        input  wire [ex_pkg::DATA_W-1:0]        i_rs_data,
        input  wire [ex_pkg::DATA_W-1:0]        i_rt_data,
        input  wire [ex_pkg::IMM_W-1:0]         i_imm,
        input  wire [ex_pkg::REG_ADDR_W-1:0]    i_rt_addr,
        input  wire [ex_pkg::REG_ADDR_W-1:0]    i_rd_addr,
        input  wire [ex_pkg::DATA_W-1:0]        i_pc_link,
        output logic                            o_valid,
        output logic [ex_pkg::DATA_W-1:0]       o_result,
        output logic [ex_pkg::REG_ADDR_W-1:0]   o_wr_addr,
        output logic                            o_wr_en,
        output logic                            o_mem_rd,
        output logic                            o_mem_wr,
        output logic                            o_branch_taken
);
        import ex_pkg::*;

        // ID/EX register outputs
        logic                  id_valid;
        opcode_e               id_opcode;
        funct_e                id_funct;
        logic [SHAMT_W-1:0]    id_shamt;
        logic [DATA_W-1:0]     id_rs_data;
        logic [DATA_W-1:0]     id_rt_data;
        logic [DATA_W-1:0]     id_imm_ext;
        logic                  id_imm_sel;
        dest_sel_e             id_dest_sel;
        logic                  id_mem_rd;
        logic                  id_mem_wr;
        logic [REG_ADDR_W-1:0] id_rt_addr;
        logic [REG_ADDR_W-1:0] id_rd_addr;
        logic [DATA_W-1:0]     id_pc_link;

        alu_op_e               alu_ctrl;
        logic                  shamt_ctrl;
        logic                  r31_ctrl;
        logic                  illegal;
        logic [DATA_W-1:0]     alu_result;
        logic                  branch_cond;

        ex_id_latch id_latch_inst (
                .i_clk      (i_clk),       .i_rst_n   (i_rst_n),
                .i_valid    (i_valid),     .i_opcode  (i_opcode),
                .i_funct    (i_funct),     .i_shamt   (i_shamt),
                .i_rs_data  (i_rs_data),   .i_rt_data (i_rt_data),
                .i_imm      (i_imm),       .i_rt_addr (i_rt_addr),
                .i_rd_addr  (i_rd_addr),   .i_pc_link (i_pc_link),
                .o_valid    (id_valid),    .o_opcode  (id_opcode),
                .o_funct    (id_funct),    .o_shamt   (id_shamt),
                .o_rs_data  (id_rs_data),  .o_rt_data (id_rt_data),
                .o_imm_ext  (id_imm_ext),  .o_imm_sel (id_imm_sel),
                .o_dest_sel (id_dest_sel), .o_mem_rd  (id_mem_rd),
                .o_mem_wr   (id_mem_wr),   .o_rt_addr (id_rt_addr),
                .o_rd_addr  (id_rd_addr),  .o_pc_link (id_pc_link)
        );

        alu_control alu_control_inst (
                .i_funct_code (id_funct),
                .i_alu_op     (id_opcode),
                .o_alu_ctrl   (alu_ctrl),
                .o_shamt_ctrl (shamt_ctrl),
                .o_r31_ctrl   (r31_ctrl),
                .o_illegal    (illegal)
        );

        ex_alu alu_inst (
                .i_alu_ctrl    (alu_ctrl),   .i_shamt_ctrl (shamt_ctrl),
                .i_imm_sel     (id_imm_sel), .i_shamt      (id_shamt),
                .i_rs_data     (id_rs_data), .i_rt_data    (id_rt_data),
                .i_imm_ext     (id_imm_ext), .o_result     (alu_result),
                .o_branch_cond (branch_cond)
        );

        ex_result_latch result_latch_inst (
                .i_clk         (i_clk),       .i_rst_n        (i_rst_n),
                .i_valid       (id_valid),    .i_alu_result   (alu_result),
                .i_branch_cond (branch_cond), .i_r31_ctrl     (r31_ctrl),
                .i_illegal     (illegal),     .i_dest_sel     (id_dest_sel),
                .i_mem_rd      (id_mem_rd),   .i_mem_wr       (id_mem_wr),
                .i_rt_addr     (id_rt_addr),  .i_rd_addr      (id_rd_addr),
                .i_pc_link     (id_pc_link),  .i_alu_op       (alu_ctrl),
                .o_valid       (o_valid),     .o_result       (o_result),
                .o_wr_addr     (o_wr_addr),   .o_wr_en        (o_wr_en),
                .o_mem_rd      (o_mem_rd),    .o_mem_wr       (o_mem_wr),
                .o_branch_taken(o_branch_taken)
        );

endmodule

`default_nettype wire

//--- sim/ex_vectors.svh
        // Columns: opcode, funct, shamt, rt addr, rd addr, expected write address, rs, rt,
        // imm, link value, expected result, flags {check result, wr_en, mem_rd, mem_wr, taken}
        localparam int NUM_ROWS = 30;

        row_t rows [NUM_ROWS] = '{
                '{OP_RTYPE, FN_ADD, 0, 2, 3, 3, 'h7fffffff, 'h1, 0, 0, 'h80000000, 'b11000},
                '{OP_RTYPE, FN_ADDU, 0, 2, 4, 4, 'h7fffffff, 'h1, 0, 0, 'h80000000, 'b11000},
                '{OP_RTYPE, FN_SUB, 0, 2, 5, 5, 'h5, 'h9, 0, 0, 'hfffffffc, 'b11000},
                '{OP_RTYPE, FN_XOR, 0, 2, 6, 6, 'hffff0000, 'h0f0f0f0f, 0, 0, 'hf0f00f0f, 'b11000},
                '{OP_RTYPE, FN_NOR, 0, 2, 7, 7, 'h0000ffff, 'h00ff0000, 0, 0, 'hff000000, 'b11000},
                '{OP_RTYPE, FN_SLT, 0, 2, 8, 8, 'hfffffffe, 'h1, 0, 0, 'h1, 'b11000},
                '{OP_RTYPE, FN_SLT, 0, 2, 9, 9, 'h5, 'hffffffff, 0, 0, 'h0, 'b11000},
                '{OP_RTYPE, FN_SLL, 4, 2, 10, 10, 'h1f, 'h8000000f, 0, 0, 'hf0, 'b11000},
                '{OP_RTYPE, FN_SRL, 8, 2, 11, 11, 'h1, 'h80000000, 0, 0, 'h00800000, 'b11000},
                '{OP_RTYPE, FN_SRA, 8, 2, 12, 12, 'h2, 'h80000000, 0, 0, 'hff800000, 'b11000},
                '{OP_RTYPE, FN_SLLV, 7, 2, 13, 13, 'hffffffe3, 'h11, 0, 0, 'h88, 'b11000},
                '{OP_RTYPE, FN_SRLV, 1, 2, 14, 14, 'h24, 'hf0000000, 0, 0, 'h0f000000, 'b11000},
                '{OP_RTYPE, FN_SRAV, 2, 2, 15, 15, 'h61, 'h80000000, 0, 0, 'hc0000000, 'b11000},
                '{OP_ADDI, FN_SLL, 0, 17, 3, 17, 'h1000, 0, 'hfffc, 0, 'hffc, 'b11000},
                '{OP_SLTI, FN_SLL, 0, 18, 3, 18, 'h5, 0, 'hfff8, 0, 'h0, 'b11000},
                '{OP_ANDI, FN_SLL, 0, 19, 3, 19, 'hffffffff, 0, 'h8001, 0, 'h8001, 'b11000},
                '{OP_ORI, FN_SLL, 0, 20, 3, 20, 'h12340000, 0, 'h8000, 0, 'h12348000, 'b11000},
                '{OP_XORI, FN_SLL, 0, 21, 3, 21, 'hffff00ff, 0, 'h80f0, 0, 'hffff800f, 'b11000},
                '{OP_LUI, FN_SLL, 0, 22, 3, 22, 'h12345678, 0, 'hbeef, 0, 'hbeef0000, 'b11000},
                '{OP_LW, FN_SLL, 0, 23, 3, 0, 'h1000, 0, 'hfff0, 0, 'hff0, 'b10100}, // Address only
                '{OP_SW, FN_SLL, 0, 24, 3, 0, 'h2000, 'hdeadbeef, 'h8000, 0, 'hffffa000, 'b10010},
                '{OP_BEQ, FN_SLL, 0, 1, 2, 0, 'h55, 'h55, 'h10, 0, 'h0, 'b10001},
                '{OP_BEQ, FN_SLL, 0, 1, 2, 0, 'h55, 'h56, 'h10, 0, 'h0, 'b10000},
                '{OP_BNE, FN_SLL, 0, 1, 2, 0, 'h55, 'h56, 'h10, 0, 'h0, 'b10001},
                '{OP_BNE, FN_SLL, 0, 1, 2, 0, 'h7, 'h7, 'h10, 0, 'h0, 'b10000},
                '{OP_JAL, FN_SLL, 0, 0, 0, 31, 0, 0, 0, 'h400008, 'h400008, 'b11000},
                '{OP_RTYPE, FN_JALR, 0, 0, 5, 31, 'h400100, 0, 0, 'h40000c, 'h40000c, 'b11000},
                '{opcode_e'(6'h3f), FN_ADD, 0, 1, 2, 0, 'h1, 'h2, 0, 0, 'h0, 'b00000},
                '{OP_RTYPE, funct_e'(6'h3f), 0, 1, 2, 0, 'h1, 'h2, 0, 0, 'h0, 'b00000},
                '{OP_RTYPE, FN_ADDU, 0, 1, 26, 26, 'h3, 'h4, 0, 0, 'h7, 'b11000}
        };

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
        import ex_pkg::*;

        typedef struct {
                opcode_e               op;
                funct_e                fn;
                logic [SHAMT_W-1:0]    sh;
                logic [REG_ADDR_W-1:0] rta, rda, wa;
                logic [DATA_W-1:0]     rs, rt;
                logic [IMM_W-1:0]      imm;
                logic [DATA_W-1:0]     link, res;
                logic [4:0]            flags; // Check result, wr_en, mem_rd, mem_wr, taken
        } row_t;

        `include "ex_vectors.svh"

        logic                  clk;
        logic                  rst_n;
        logic                  valid;
        row_t                  cur;           // Row on the DUT inputs
        logic                  out_valid, wr_en, mem_rd, mem_wr, taken;
        logic [DATA_W-1:0]     result;
        logic [REG_ADDR_W-1:0] wr_addr;

        ex_stage ex_stage_inst (
                .i_clk     (clk),     .i_rst_n   (rst_n),    .i_valid   (valid),
                .i_opcode  (cur.op),  .i_funct   (cur.fn),   .i_shamt   (cur.sh),
                .i_rs_data (cur.rs),  .i_rt_data (cur.rt),   .i_imm     (cur.imm),
                .i_rt_addr (cur.rta), .i_rd_addr (cur.rda),  .i_pc_link (cur.link),
                .o_valid   (out_valid), .o_result (result),  .o_wr_addr (wr_addr),
                .o_wr_en   (wr_en),   .o_mem_rd  (mem_rd),   .o_mem_wr  (mem_wr),
                .o_branch_taken (taken)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        initial begin
                #((NUM_ROWS + 20) * 40); // Every row plus reset and drain
                $display("Timeout: the table did not finish within the time limit");
                $display("RESULT: FAIL");
                $fatal(1, "Watchdog expired");
        end

        task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
                        $display("RESULT: FAIL");
                        $fatal(1, "Mismatch on %s", name);
                end
        endtask

        // An index outside the table means the pipeline slot is empty
        task automatic check_outputs(input int idx);
                logic       live;
                logic [4:0] f;
                live = (idx >= 0) && (idx < NUM_ROWS);
                f    = '0;
                if (live)
                        f = rows[idx].flags;
                compare("o_valid", out_valid, live);
                compare("o_wr_en", wr_en, f[3]);
                compare("o_mem_rd", mem_rd, f[2]);
                compare("o_mem_wr", mem_wr, f[1]);
                compare("o_branch_taken", taken, f[0]);
                if (f[4])
                        compare("o_result", result, rows[idx].res);
                if (f[3])
                        compare("o_wr_addr", wr_addr, rows[idx].wa);
        endtask

        initial begin
                valid = 1'b0;
                rst_n = 1'b0;
                cur   = rows[0];
                repeat (3) @(negedge clk);
                rst_n = 1'b1;
                // Row c shows up on the outputs two falling edges later
                for (int c = 0; c < NUM_ROWS + 4; c++) begin
                        @(negedge clk);
                        check_outputs(c - 2);
                        valid = (c < NUM_ROWS);
                        if (c < NUM_ROWS)
                                cur = rows[c];
                end
                $display("RESULT: PASS");
                $finish;
        end

endmodule

`default_nettype wire

//--- files.f
+incdir+sim
design/ex_pkg.sv
design/ex_id_latch.sv
design/alu_control.sv
design/ex_alu.sv
design/ex_result_latch.sv
design/ex_stage.sv
sim/tb_ex_stage.sv
